// ==== src/id_pkg.sv ====
`default_nettype none

package id_pkg;

    typedef logic [31:0] word_t;      // data or address word
    typedef logic [4:0]  reg_addr_t;  // register index

    localparam int unsigned NUM_REGS = 32;
    localparam reg_addr_t   LINK_REG = 5'd31;  // jal return address

    // primary opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_REGIMM  = 6'h01;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_JAL     = 6'h03;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_SLTI    = 6'h0a;
    localparam logic [5:0] OPC_SLTIU   = 6'h0b;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_XORI    = 6'h0e;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;

    // SPECIAL function codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // REGIMM selects live in the rt field
    localparam reg_addr_t RT_BLTZ = 5'd0;
    localparam reg_addr_t RT_BGEZ = 5'd1;

    // testbench run control
    localparam int unsigned TB_SEED   = 38938;
    localparam int unsigned NUM_TESTS = 2000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS, SRC1_PC, SRC1_SA} src1_e;

    typedef enum logic [1:0] {SRC2_RT, SRC2_SIMM, SRC2_ZIMM, SRC2_C8} src2_e;

    typedef struct packed {
        alu_op_e   alu_op;
        src1_e     src1;
        src2_e     src2;
        logic      mem_en;    // lw or sw
        logic      mem_we;    // sw only
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      sel_load;  // writeback takes load data
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
    } fetch_t;

    // register write, also used as bypass bus
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_write_t;

    typedef struct packed {
        logic id_stall;
        logic ex_stall;
    } stall_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
        ctrl_t ctrl;
        word_t rdata1;  // rs after bypass
        word_t rdata2;  // rt after bypass
    } id_ex_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_t;

endpackage

`default_nettype wire

// ==== src/id_stall_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_stall_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  id_pkg::fetch_t fetch_i,
    input  id_pkg::word_t  inst_i,
    input  id_pkg::stall_t stall_i,
    output id_pkg::word_t  pc_o,
    output id_pkg::word_t  inst_o,
    output logic           issue_o
);
    import id_pkg::*;

    typedef enum logic {
        RUN,   // word comes straight from imem
        HOLD   // word comes from hold_q
    } state_e;

    state_e state_q;
    state_e state_d;
    fetch_t fetch_q;   // pc and valid of the instruction in ID
    word_t  hold_q;    // word captured on stall entry
    logic   freeze;
    logic   capture;

    // ex stall normally comes with id stall, treat either as a freeze
    assign freeze  = stall_i.id_stall || stall_i.ex_stall;
    assign capture = (state_q == RUN) && freeze;  // imem word still valid this cycle

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            RUN: begin
                if (freeze) begin
                    state_d = HOLD;
                end
            end
            HOLD: begin
                if (!freeze) begin
                    state_d = RUN;  // fetch reg loads the next pc on this edge
                end
            end
            default: state_d = RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= RUN;
            fetch_q <= '0;   // valid low after reset
        end else begin
            state_q <= state_d;
            if (!freeze) begin
                fetch_q <= fetch_i;
            end
        end
    end

    // hold register, payload only
    always_ff @(posedge clk) begin
        if (capture) begin
            hold_q <= inst_i;
        end
    end

    assign pc_o    = fetch_q.pc;
    assign inst_o  = (state_q == HOLD) ? hold_q : inst_i;
    assign issue_o = fetch_q.valid && !stall_i.id_stall;  // bubble while id is stalled

endmodule

`default_nettype wire

// ==== src/id_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_decoder (
    input  id_pkg::word_t     inst_i,
    output id_pkg::ctrl_t     ctrl_o,
    output id_pkg::reg_addr_t rs_o,
    output id_pkg::reg_addr_t rt_o
);
    import id_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic       sa_zero;   // shamt field clear
    logic       rs_zero;   // rs field clear
    alu_op_e    r_op;      // SPECIAL group op
    logic       r_ok;      // legal SPECIAL ALU encoding
    logic       r_shift;   // sll/srl/sra take shamt
    alu_op_e    imm_op;    // immediate group op
    logic       imm_zext;  // logical immediates are zero extended
    logic       imm_ok;

    assign opcode  = inst_i[31:26];
    assign rs_o    = inst_i[25:21];
    assign rt      = inst_i[20:16];
    assign rd      = inst_i[15:11];
    assign funct   = inst_i[5:0];
    assign sa_zero = (inst_i[10:6] == '0);
    assign rs_zero = (inst_i[25:21] == '0);
    assign rt_o    = rt;

    // SPECIAL function field
    always_comb begin
        r_op    = ALU_ADD;
        r_ok    = sa_zero;
        r_shift = 1'b0;
        case (funct)
            FN_ADDU: r_op = ALU_ADD;
            FN_SUBU: r_op = ALU_SUB;
            FN_AND:  r_op = ALU_AND;
            FN_OR:   r_op = ALU_OR;
            FN_XOR:  r_op = ALU_XOR;
            FN_NOR:  r_op = ALU_NOR;
            FN_SLT:  r_op = ALU_SLT;
            FN_SLTU: r_op = ALU_SLTU;
            FN_SLL, FN_SRL, FN_SRA: begin
                r_shift = 1'b1;
                r_ok    = rs_zero;  // shifts need rs clear, shamt is free
                r_op    = (funct == FN_SLL) ? ALU_SLL :
                          (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
            end
            default: r_ok = 1'b0;   // jr and the rest write nothing
        endcase
    end

    // immediate group
    always_comb begin
        case (opcode)
            OPC_SLTI:  imm_op = ALU_SLT;
            OPC_SLTIU: imm_op = ALU_SLTU;
            OPC_ANDI:  imm_op = ALU_AND;
            OPC_ORI:   imm_op = ALU_OR;
            OPC_XORI:  imm_op = ALU_XOR;
            OPC_LUI:   imm_op = ALU_LUI;
            default:   imm_op = ALU_ADD;  // addiu
        endcase
    end

    assign imm_zext = (opcode == OPC_ANDI) || (opcode == OPC_ORI) || (opcode == OPC_XORI);
    assign imm_ok   = (opcode != OPC_LUI) || rs_zero;

    always_comb begin
        ctrl_o        = '0;   // unknown encoding, all enables low
        ctrl_o.alu_op = ALU_ADD;
        ctrl_o.src1   = SRC1_RS;
        ctrl_o.src2   = SRC2_RT;
        case (opcode)
            OPC_SPECIAL: begin
                if (r_ok) begin
                    ctrl_o.alu_op   = r_op;
                    ctrl_o.src1     = r_shift ? SRC1_SA : SRC1_RS;
                    ctrl_o.rf_we    = 1'b1;
                    ctrl_o.rf_waddr = rd;
                end
            end
            OPC_ADDIU, OPC_SLTI, OPC_SLTIU, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI: begin
                if (imm_ok) begin
                    ctrl_o.alu_op   = imm_op;
                    ctrl_o.src2     = imm_zext ? SRC2_ZIMM : SRC2_SIMM;
                    ctrl_o.rf_we    = 1'b1;
                    ctrl_o.rf_waddr = rt;
                end
            end
            OPC_LW: begin
                ctrl_o.src2     = SRC2_SIMM;  // base + offset
                ctrl_o.mem_en   = 1'b1;
                ctrl_o.rf_we    = 1'b1;
                ctrl_o.rf_waddr = rt;
                ctrl_o.sel_load = 1'b1;
            end
            OPC_SW: begin
                ctrl_o.src2   = SRC2_SIMM;
                ctrl_o.mem_en = 1'b1;
                ctrl_o.mem_we = 1'b1;
            end
            OPC_JAL: begin
                ctrl_o.src1     = SRC1_PC;  // link value is pc + 8
                ctrl_o.src2     = SRC2_C8;
                ctrl_o.rf_we    = 1'b1;
                ctrl_o.rf_waddr = LINK_REG;
            end
            default: ctrl_o.alu_op = ALU_ADD;  // branches, j, unknown
        endcase
    end

endmodule

`default_nettype wire

// ==== src/id_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_regfile (
    input  logic              clk,
    input  logic              rst,
    input  id_pkg::reg_addr_t rs_i,
    input  id_pkg::reg_addr_t rt_i,
    input  id_pkg::wb_write_t rf_write_i,
    input  id_pkg::wb_write_t ex_fwd_i,
    input  id_pkg::wb_write_t mem_fwd_i,
    input  id_pkg::wb_write_t wb_fwd_i,
    input  logic              ex_is_load_i,
    output id_pkg::word_t     rdata1_o,
    output id_pkg::word_t     rdata2_o,
    output logic              stall_req_o
);
    import id_pkg::*;

    word_t regs [NUM_REGS];

    // bus writes this nonzero register
    function automatic logic hits(input wb_write_t bus, input reg_addr_t addr);
        return bus.we && (bus.waddr == addr) && (addr != '0);
    endfunction

    // EX first, then MEM, then WB, else the array
    function automatic word_t operand(input reg_addr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (hits(ex_fwd_i, addr)) begin
            val = ex_fwd_i.wdata;
        end else if (hits(mem_fwd_i, addr)) begin
            val = mem_fwd_i.wdata;
        end else if (hits(wb_fwd_i, addr)) begin
            val = wb_fwd_i.wdata;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_write_i.we && (rf_write_i.waddr != '0)) begin
            regs[rf_write_i.waddr] <= rf_write_i.wdata;  // r0 stays zero
        end
    end

    always_comb begin
        rdata1_o = operand(rs_i);
        rdata2_o = operand(rt_i);
    end

    // load in EX, its data only exists after MEM
    assign stall_req_o = ex_is_load_i && (ex_fwd_i.waddr != '0)
                       && ((ex_fwd_i.waddr == rs_i) || (ex_fwd_i.waddr == rt_i));

endmodule

`default_nettype wire

// ==== src/id_branch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_branch_unit (
    input  id_pkg::word_t   pc_i,
    input  id_pkg::word_t   inst_i,
    input  id_pkg::word_t   rdata1_i,
    input  id_pkg::word_t   rdata2_i,
    input  logic            issue_i,
    output id_pkg::branch_t br_o
);
    import id_pkg::*;

    logic [5:0] opcode;
    logic       is_jr;
    logic       cond;        // branch or jump taken before issue gating
    word_t      pc_plus4;
    word_t      rel_target;  // pc-relative
    word_t      abs_target;  // 256 MB region of pc + 4
    word_t      target;

    assign opcode     = inst_i[31:26];
    assign pc_plus4   = pc_i + 32'd4;
    assign rel_target = pc_plus4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign abs_target = {pc_plus4[31:28], inst_i[25:0], 2'b00};
    assign is_jr      = (opcode == OPC_SPECIAL) && (inst_i[5:0] == FN_JR)
                      && (inst_i[20:6] == '0);

    always_comb begin
        cond   = 1'b0;
        target = pc_plus4;  // fall through
        case (opcode)
            OPC_BEQ: begin
                cond   = (rdata1_i == rdata2_i);
                target = rel_target;
            end
            OPC_BNE: begin
                cond   = (rdata1_i != rdata2_i);
                target = rel_target;
            end
            OPC_REGIMM: begin
                target = rel_target;
                if (inst_i[20:16] == RT_BGEZ) begin
                    cond = !rdata1_i[31];  // sign bit clear
                end else if (inst_i[20:16] == RT_BLTZ) begin
                    cond = rdata1_i[31];
                end
            end
            OPC_J, OPC_JAL: begin
                cond   = 1'b1;
                target = abs_target;
            end
            default: begin
                if (is_jr) begin
                    cond   = 1'b1;
                    target = rdata1_i;  // bypassed rs
                end
            end
        endcase
    end

    assign br_o.taken  = issue_i && cond;  // never on a bubble
    assign br_o.target = target;

endmodule

`default_nettype wire

// ==== src/id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_stage (
    input  logic              clk,
    input  logic              rst,
    input  id_pkg::fetch_t    fetch_i,
    input  id_pkg::word_t     inst_i,       // imem data for the pc registered now
    input  id_pkg::stall_t    stall_i,
    input  id_pkg::wb_write_t ex_fwd_i,
    input  id_pkg::wb_write_t mem_fwd_i,
    input  id_pkg::wb_write_t wb_fwd_i,
    input  logic              ex_is_load_i,
    input  id_pkg::wb_write_t rf_write_i,
    output id_pkg::id_ex_t    id_ex_o,
    output id_pkg::branch_t   br_o,
    output logic              stall_req_o
);
    import id_pkg::*;

    word_t     pc;
    word_t     inst;      // live or held word
    logic      issue;
    ctrl_t     ctrl;
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     rdata1;
    word_t     rdata2;

    id_stall_ctrl u_stall_ctrl (
        .clk     (clk),
        .rst     (rst),
        .fetch_i (fetch_i),
        .inst_i  (inst_i),
        .stall_i (stall_i),
        .pc_o    (pc),
        .inst_o  (inst),
        .issue_o (issue)
    );

    id_decoder u_decoder (
        .inst_i (inst),
        .ctrl_o (ctrl),
        .rs_o   (rs),
        .rt_o   (rt)
    );

    id_regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .rs_i         (rs),
        .rt_i         (rt),
        .rf_write_i   (rf_write_i),
        .ex_fwd_i     (ex_fwd_i),
        .mem_fwd_i    (mem_fwd_i),
        .wb_fwd_i     (wb_fwd_i),
        .ex_is_load_i (ex_is_load_i),
        .rdata1_o     (rdata1),
        .rdata2_o     (rdata2),
        .stall_req_o  (stall_req_o)
    );

    id_branch_unit u_branch (
        .pc_i     (pc),
        .inst_i   (inst),
        .rdata1_i (rdata1),
        .rdata2_i (rdata2),
        .issue_i  (issue),
        .br_o     (br_o)
    );

    assign id_ex_o.valid  = issue;  // low is a bubble to EX
    assign id_ex_o.pc     = pc;
    assign id_ex_o.inst   = inst;
    assign id_ex_o.ctrl   = ctrl;
    assign id_ex_o.rdata1 = rdata1;
    assign id_ex_o.rdata2 = rdata2;

endmodule

`default_nettype wire

// ==== test/id_stage_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_stage_properties (
    input logic            clk,
    input logic            rst,
    input id_pkg::stall_t  stall_i,
    input id_pkg::id_ex_t  id_ex_o,
    input id_pkg::branch_t br_o
);

    // pc and word stay put across a stalled edge
    stall_keeps_inst: assert property (
        @(posedge clk) disable iff (rst)
        stall_i.id_stall |=> $stable(id_ex_o.pc) && $stable(id_ex_o.inst)
    ) else $error("pc or instruction changed across an id stall");

    // fetch register comes out of reset cleared, so no issue and no branch
    idle_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> !id_ex_o.valid && !br_o.taken
    ) else $error("id_ex valid or branch taken high in the first cycle after reset");

endmodule

`default_nettype wire

// ==== test/tb_id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_id_stage;
    import id_pkg::*;

    logic      clk;
    logic      rst;
    fetch_t    fetch_in;
    word_t     inst_in;
    stall_t    stall_in;
    wb_write_t ex_fwd, mem_fwd, wb_fwd, rf_write;
    logic      ex_is_load;
    id_ex_t    dut_ex;
    branch_t   dut_br;
    logic      dut_stall_req;

    word_t      model_regs [NUM_REGS];  // mirror of the register file
    fetch_t     m_fetch;                // expected fetch register
    word_t      m_hold;
    logic       m_in_hold;              // expected HOLD state
    logic       check_en;
    int         ex_errs, br_errs, stall_errs;
    logic [5:0] r_fn_tab [8] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    logic [5:0] i_op_tab [7] = '{OPC_ADDIU, OPC_SLTI, OPC_SLTIU, OPC_ANDI, OPC_ORI, OPC_XORI,
                                 OPC_LUI};

    id_stage dut0 (
        .clk(clk), .rst(rst), .fetch_i(fetch_in), .inst_i(inst_in), .stall_i(stall_in),
        .ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd), .wb_fwd_i(wb_fwd), .ex_is_load_i(ex_is_load),
        .rf_write_i(rf_write), .id_ex_o(dut_ex), .br_o(dut_br), .stall_req_o(dut_stall_req)
    );

    bind id_stage id_stage_properties u_props (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // expected control word per instruction encoding
    function automatic ctrl_t expected_ctrl(input word_t inst);
        ctrl_t     c;
        logic [5:0] op, fn;
        reg_addr_t rs, rt, rd;
        op = inst[31:26];
        fn = inst[5:0];
        rs = inst[25:21];
        rt = inst[20:16];
        rd = inst[15:11];
        c  = '0;
        if (op == OPC_SPECIAL) begin
            if (inst[10:6] == 5'd0 && fn inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                                                 FN_NOR, FN_SLT, FN_SLTU}) begin
                case (fn)
                    FN_SUBU: c.alu_op = ALU_SUB;
                    FN_AND:  c.alu_op = ALU_AND;
                    FN_OR:   c.alu_op = ALU_OR;
                    FN_XOR:  c.alu_op = ALU_XOR;
                    FN_NOR:  c.alu_op = ALU_NOR;
                    FN_SLT:  c.alu_op = ALU_SLT;
                    FN_SLTU: c.alu_op = ALU_SLTU;
                    default: c.alu_op = ALU_ADD;
                endcase
                c.rf_we = 1'b1;
                c.rf_waddr = rd;
            end else if (rs == 5'd0 && fn inside {FN_SLL, FN_SRL, FN_SRA}) begin
                c.alu_op = (fn == FN_SLL) ? ALU_SLL : (fn == FN_SRL) ? ALU_SRL : ALU_SRA;
                c.src1 = SRC1_SA;  // shift amount from shamt
                c.rf_we = 1'b1;
                c.rf_waddr = rd;
            end
        end else if (op inside {OPC_ADDIU, OPC_SLTI, OPC_SLTIU, OPC_ANDI, OPC_ORI, OPC_XORI,
                                OPC_LUI}) begin
            if (op != OPC_LUI || rs == 5'd0) begin
                case (op)
                    OPC_SLTI:  c.alu_op = ALU_SLT;
                    OPC_SLTIU: c.alu_op = ALU_SLTU;
                    OPC_ANDI:  c.alu_op = ALU_AND;
                    OPC_ORI:   c.alu_op = ALU_OR;
                    OPC_XORI:  c.alu_op = ALU_XOR;
                    OPC_LUI:   c.alu_op = ALU_LUI;
                    default:   c.alu_op = ALU_ADD;
                endcase
                c.src2 = (op inside {OPC_ANDI, OPC_ORI, OPC_XORI}) ? SRC2_ZIMM : SRC2_SIMM;
                c.rf_we = 1'b1;
                c.rf_waddr = rt;
            end
        end else if (op == OPC_LW) begin
            c.src2 = SRC2_SIMM;
            c.mem_en = 1'b1;
            c.rf_we = 1'b1;
            c.rf_waddr = rt;
            c.sel_load = 1'b1;
        end else if (op == OPC_SW) begin
            c.src2 = SRC2_SIMM;
            c.mem_en = 1'b1;
            c.mem_we = 1'b1;
        end else if (op == OPC_JAL) begin
            c.src1 = SRC1_PC;  // link = pc + 8
            c.src2 = SRC2_C8;
            c.rf_we = 1'b1;
            c.rf_waddr = LINK_REG;
        end
        return c;
    endfunction

    // EX over MEM over WB over the model array
    function automatic word_t expected_operand(input reg_addr_t a);
        if (a == 5'd0) return '0;
        if (ex_fwd.we && ex_fwd.waddr == a) return ex_fwd.wdata;
        if (mem_fwd.we && mem_fwd.waddr == a) return mem_fwd.wdata;
        if (wb_fwd.we && wb_fwd.waddr == a) return wb_fwd.wdata;
        return model_regs[a];
    endfunction

    function automatic void ref_decode(input word_t pc, input word_t inst, input logic valid,
                                       input logic id_stall, output id_ex_t e,
                                       output branch_t b, output logic st);
        word_t p4, rel, r1, r2;
        logic  cond;
        r1   = expected_operand(inst[25:21]);
        r2   = expected_operand(inst[20:16]);
        p4   = pc + 32'd4;
        rel  = p4 + {{14{inst[15]}}, inst[15:0], 2'b00};
        cond = 1'b0;
        b.target = p4;
        case (inst[31:26])
            OPC_BEQ: begin
                cond     = (r1 == r2);
                b.target = rel;
            end
            OPC_BNE: begin
                cond     = (r1 != r2);
                b.target = rel;
            end
            OPC_REGIMM: begin
                b.target = rel;
                cond = (inst[20:16] == RT_BGEZ) ? !r1[31] : (inst[20:16] == RT_BLTZ) && r1[31];
            end
            OPC_J, OPC_JAL: begin
                cond     = 1'b1;
                b.target = {p4[31:28], inst[25:0], 2'b00};
            end
            OPC_SPECIAL: begin
                if (inst[5:0] == FN_JR && inst[20:6] == 15'd0) begin
                    cond = 1'b1;
                    b.target = r1;
                end
            end
            default: cond = 1'b0;
        endcase
        b.taken  = cond && valid && !id_stall;
        e.valid  = valid && !id_stall;
        e.pc     = pc;
        e.inst   = inst;
        e.ctrl   = expected_ctrl(inst);
        e.rdata1 = r1;
        e.rdata2 = r2;
        st = ex_is_load && ex_fwd.waddr != 5'd0
             && (ex_fwd.waddr == inst[25:21] || ex_fwd.waddr == inst[20:16]);
    endfunction

    task automatic check_ex_bus(input id_ex_t got, input id_ex_t exp);
        if (got !== exp) begin
            ex_errs++;
            $display("FAILED %0t: id_ex got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_branch(input branch_t got, input branch_t exp);
        if (got !== exp) begin
            br_errs++;
            $display("FAILED %0t: branch got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            stall_errs++;
            $display("FAILED %0t: stall_req got %b expected %b", $time, got, exp);
        end
    endtask

    function automatic word_t rand_inst();
        reg_addr_t  rs, rt, rd;
        logic [15:0] imm;
        logic [5:0] op;
        int unsigned x;
        rs = 5'($urandom % 8);  // small index range makes bypass hits frequent
        rt = 5'($urandom % 8);
        rd = 5'($urandom % 8);
        imm = 16'($urandom);
        x = $urandom % 3;
        case ($urandom % 10)
            0, 1: return {OPC_SPECIAL, rs, rt, rd, 5'd0, r_fn_tab[$urandom % 8]};
            2: return {OPC_SPECIAL, 5'd0, rt, rd, 5'($urandom),
                       (x == 0) ? FN_SLL : (x == 1) ? FN_SRL : FN_SRA};
            3: begin
                op = i_op_tab[$urandom % 7];
                return {op, (op == OPC_LUI) ? 5'd0 : rs, rt, imm};
            end
            4: return {($urandom % 2) ? OPC_LW : OPC_SW, rs, rt, imm};
            5: return {($urandom % 2) ? OPC_BEQ : OPC_BNE, rs, rt, imm};
            6: return {OPC_REGIMM, rs, 5'($urandom % 2), imm};
            7: return {($urandom % 2) ? OPC_JAL : OPC_J, 26'($urandom)};
            8: return {OPC_SPECIAL, rs, 15'd0, FN_JR};
            default: return $urandom;  // mostly unknown encodings
        endcase
    endfunction

    function automatic wb_write_t rand_bus();
        return '{we: 1'($urandom), waddr: 5'($urandom % 8), wdata: $urandom};
    endfunction

    task automatic next_drive_slot();
        @(posedge clk);
        #5;  // inputs change just after the edge
    endtask

    task automatic drive_random(input logic allow_stall);
        fetch_in   = '{valid: 1'b1, pc: $urandom & 32'hffff_fffc};
        inst_in    = rand_inst();
        stall_in   = '{id_stall: allow_stall && ($urandom % 6 == 0), ex_stall: 1'b0};
        ex_fwd     = rand_bus();
        mem_fwd    = rand_bus();
        wb_fwd     = rand_bus();
        rf_write   = rand_bus();
        ex_is_load = 1'($urandom);
    endtask

    // reference state follows the same edges as the DUT
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) model_regs[i] <= '0;
            m_fetch   <= '0;
            m_in_hold <= 1'b0;
        end else begin
            if (rf_write.we && rf_write.waddr != 5'd0) model_regs[rf_write.waddr] <= rf_write.wdata;
            if (!stall_in.id_stall && !stall_in.ex_stall) m_fetch <= fetch_in;
            if (!m_in_hold && stall_in.id_stall) begin
                m_in_hold <= 1'b1;
                m_hold    <= inst_in;  // word captured on stall entry
            end else if (m_in_hold && !stall_in.id_stall) begin
                m_in_hold <= 1'b0;
            end
        end
    end

    // compares at mid cycle once inputs have settled
    initial begin : compare_proc
        id_ex_t  e;
        branch_t b;
        logic    st;
        forever begin
            @(posedge clk);
            #45;
            if (check_en) begin
                ref_decode(m_fetch.pc, m_in_hold ? m_hold : inst_in, m_fetch.valid,
                           stall_in.id_stall, e, b, st);
                check_ex_bus(dut_ex, e);
                check_branch(dut_br, b);
                check_stall(dut_stall_req, st);
            end
        end
    end

    initial begin : watchdog
        #((NUM_TESTS + 300) * 100);
        $display("timeout: the test sequence did not complete in time");
        $display("sim failed");
        $finish;
    end

    initial begin : stimulus
        word_t held_pc, held_inst;
        rst = 1'b1;
        check_en = 1'b0;
        ex_errs = 0;
        br_errs = 0;
        stall_errs = 0;
        fetch_in = '0;
        inst_in = '0;
        stall_in = '0;
        ex_fwd = '0;
        mem_fwd = '0;
        wb_fwd = '0;
        rf_write = '0;
        ex_is_load = 1'b0;
        void'($urandom(TB_SEED));
        repeat (5) @(posedge clk);
        #5;
        rst = 1'b0;
        check_en = 1'b1;  // reference sees a cleared fetch register first
        // fill the register file with the bypass buses idle
        for (int r = 1; r < NUM_REGS; r++) begin
            next_drive_slot();
            drive_random(1'b0);
            {ex_fwd.we, mem_fwd.we, wb_fwd.we, ex_is_load} = '0;
            rf_write = '{we: 1'b1, waddr: 5'(r), wdata: $urandom};
        end
        // all three buses on the same source register
        next_drive_slot();
        drive_random(1'b0);
        inst_in  = {OPC_SPECIAL, 5'd5, 5'd0, 5'd3, 5'd0, FN_ADDU};
        ex_fwd   = '{we: 1'b1, waddr: 5'd5, wdata: 32'h1111_1111};
        mem_fwd  = '{we: 1'b1, waddr: 5'd5, wdata: 32'h2222_2222};
        wb_fwd   = '{we: 1'b1, waddr: 5'd5, wdata: 32'h3333_3333};
        rf_write = '0;
        // load-use stall then a zero destination
        next_drive_slot();
        ex_is_load = 1'b1;
        next_drive_slot();
        ex_fwd.waddr = 5'd0;
        // stall held with a changing imem word
        next_drive_slot();
        drive_random(1'b0);
        held_pc = fetch_in.pc;
        next_drive_slot();
        drive_random(1'b0);
        held_inst = inst_in;
        stall_in.id_stall = 1'b1;
        repeat (4) begin
            next_drive_slot();
            drive_random(1'b0);
            stall_in.id_stall = 1'b1;
        end
        next_drive_slot();
        drive_random(1'b0);
        #45;
        if (dut_ex.pc !== held_pc || dut_ex.inst !== held_inst || dut_ex.valid !== 1'b1) begin
            ex_errs++;
            $display("FAILED %0t: held pc/inst %h/%h not released, got %h/%h", $time,
                     held_pc, held_inst, dut_ex.pc, dut_ex.inst);
        end
        for (int n = 0; n < NUM_TESTS; n++) begin
            next_drive_slot();
            drive_random(1'b1);
        end
        next_drive_slot();
        stall_in = '0;
        @(posedge clk);
        #50;
        check_en = 1'b0;
        $display("errors: id_ex %0d, branch %0d, stall %0d", ex_errs, br_errs, stall_errs);
        if (ex_errs + br_errs + stall_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
src/id_pkg.sv
src/id_stall_ctrl.sv
src/id_decoder.sv
src/id_regfile.sv
src/id_branch_unit.sv
src/id_stage.sv
test/id_stage_properties.sv
test/tb_id_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_id_stage
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
